//--- fifo_config.svh
/*
 sizing for the dual-clock FIFO
 FIFO_ADDR_WIDTH counts the wrap bit, so the RAM holds 2**(FIFO_ADDR_WIDTH-1)
 words; the write side reports full at depth-1, and the read output slot
 brings the usable capacity back to the full depth
 FIFO_SYNC_STAGES below 2 is not safe across unrelated clocks
*/
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// pointer width incl. wrap bit, 5 -> 16 words
`define FIFO_ADDR_WIDTH 5

// payload data bits, the last flag rides on top
`define FIFO_DATA_WIDTH 16

// destination flops per pointer synchronizer
`define FIFO_SYNC_STAGES 2

`endif

//--- fifo_pkg.sv
/*
 shared types of the dual-clock FIFO
 pointer and address widths follow the config header, so a change of
 FIFO_ADDR_WIDTH there resizes every block at once
*/
`default_nettype none
`include "fifo_config.svh"

package fifo_pkg;

	// binary pointer, msb flips on every wrap of the RAM
	typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_ptr_t;

	// RAM address = pointer without the wrap bit
	typedef logic [`FIFO_ADDR_WIDTH-2:0] ram_addr_t;

	// payload word
	typedef struct packed {
		logic [`FIFO_DATA_WIDTH-1:0] data; // user data
		logic                        last; // end of frame, passed through as is
	} fifo_word_t;

endpackage

`default_nettype wire

//--- async_fifo_dpram.sv
/*
 simple dual-port RAM, one write port and one read port on separate clocks
 read data is registered and only updates when re is high, so it holds
 its value otherwise; contents are undefined until written
 a read and a write to the same address in one cycle is not defined
*/
`timescale 1ns/1ns
`default_nettype none
`include "fifo_config.svh"

module async_fifo_dpram import fifo_pkg::*; #(
	parameter type word_t = fifo_word_t   // payload held per entry
) (
	input  wire logic      wr_clk,
	input  wire logic      rd_clk,
	input  wire logic      we,
	input  wire ram_addr_t waddr,
	input  wire word_t     wdata,
	input  wire logic      re,
	input  wire ram_addr_t raddr,
	output word_t          rdata
);

	localparam int DEPTH = 2 ** (`FIFO_ADDR_WIDTH - 1);

	word_t mem [DEPTH];

	always_ff @(posedge wr_clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	always_ff @(posedge rd_clk) begin
		if (re) begin
			rdata <= mem[raddr]; // registered read, one clock latency
		end
	end

endmodule

`default_nettype wire

//--- async_fifo_ptr_sync.sv
/*
 moves a binary FIFO pointer into another clock domain
 the source pointer must change by at most one per src_clk, so its Gray
 code flips one bit at a time and the flop chain can sample it safely
 latency is FIFO_SYNC_STAGES+1 clocks, counting the source Gray register
 all flops reset to the Gray code of 1, the pointers' reset value
*/
`timescale 1ns/1ns
`default_nettype none
`include "fifo_config.svh"

module async_fifo_ptr_sync import fifo_pkg::*; (
	input  wire logic      clk,        // destination clock
	input  wire logic      src_clk,
	input  wire logic      reset,      // destination domain
	input  wire logic      src_reset,
	input  wire fifo_ptr_t src_ptr,    // binary, src_clk domain
	output fifo_ptr_t      dst_ptr     // binary, clk domain
);

	localparam fifo_ptr_t PTR_INIT  = fifo_ptr_t'(1);
	localparam fifo_ptr_t GRAY_INIT = PTR_INIT ^ (PTR_INIT >> 1);

	fifo_ptr_t src_gray;                      // launch register, src_clk
	fifo_ptr_t sync_q [`FIFO_SYNC_STAGES];    // capture chain, clk

	function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
		fifo_ptr_t b;
		b[`FIFO_ADDR_WIDTH-1] = g[`FIFO_ADDR_WIDTH-1];
		for (int i = `FIFO_ADDR_WIDTH - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i]; // running xor from msb down
		end
		return b;
	endfunction

	// ------------------------------------------------------------------------
	// source side, register the Gray code so no logic glitch reaches clk
	// ------------------------------------------------------------------------
	always_ff @(posedge src_clk) begin
		if (src_reset) begin
			src_gray <= GRAY_INIT;
		end else begin
			src_gray <= src_ptr ^ (src_ptr >> 1);
		end
	end

	// destination chain
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `FIFO_SYNC_STAGES; s++) begin
				sync_q[s] <= GRAY_INIT;
			end
		end else begin
			sync_q[0] <= src_gray;    // first flop may go metastable
			for (int s = 1; s < `FIFO_SYNC_STAGES; s++) begin
				sync_q[s] <= sync_q[s-1];
			end
		end
	end

	assign dst_ptr = gray2bin(sync_q[`FIFO_SYNC_STAGES-1]);

endmodule

`default_nettype wire

//--- async_fifo_wr_logic.sv
/*
 write side of the dual-clock FIFO: write pointer and registered full flag
 full is computed one write ahead from the +1/+2 look-ahead pointers
 full is high during reset and on the first clock after it
 rd_ptr_sync must already be in this clock domain
 the flag is pessimistic, it clears only after the read pointer crosses over
*/
`timescale 1ns/1ns
`default_nettype none
`include "fifo_config.svh"

module async_fifo_wr_logic import fifo_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      wr_en,        // write request from upstream
	input  wire fifo_ptr_t rd_ptr_sync,  // read pointer, already synchronized
	output fifo_ptr_t      wr_ptr,       // to the pointer synchronizer
	output ram_addr_t      ram_waddr,
	output logic           ram_we,
	output logic           full
);

	logic      valid_wr;      // write accepted this clock
	logic      full_next;
	fifo_ptr_t wr_ptr_next1;  // wr_ptr + 1
	fifo_ptr_t wr_ptr_next2;  // wr_ptr + 2
	fifo_ptr_t rd_ptr_wrap;   // read pointer one lap ahead

	assign valid_wr = wr_en && !full;

	// ------------------------------------------------------------------------
	// full flag
	// ------------------------------------------------------------------------
	// full when the next slot would land on the read pointer one lap behind
	assign rd_ptr_wrap = {~rd_ptr_sync[`FIFO_ADDR_WIDTH-1],
		rd_ptr_sync[`FIFO_ADDR_WIDTH-2:0]};

	assign full_next = (wr_ptr_next1 == rd_ptr_wrap) ||
		(valid_wr && (wr_ptr_next2 == rd_ptr_wrap)); // full after this write

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b1; // hold off writes until pointers settle
		end else begin
			full <= full_next;
		end
	end

	// ------------------------------------------------------------------------
	// pointer and look-ahead copies
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= fifo_ptr_t'(1); // same start as the read side
			wr_ptr_next1 <= fifo_ptr_t'(2);
			wr_ptr_next2 <= fifo_ptr_t'(3);
		end else if (valid_wr) begin
			wr_ptr       <= wr_ptr + fifo_ptr_t'(1);
			wr_ptr_next1 <= wr_ptr + fifo_ptr_t'(2);
			wr_ptr_next2 <= wr_ptr + fifo_ptr_t'(3);
		end
	end

	assign ram_waddr = wr_ptr[`FIFO_ADDR_WIDTH-2:0]; // drop wrap bit
	assign ram_we    = valid_wr;

endmodule

`default_nettype wire

//--- async_fifo_rd_logic.sv
/*
 read side of the dual-clock FIFO: read pointer, registered empty flag and
 the valid bit of the output slot
 the output slot is the registered RAM read port, so rd_word holds while
 rd_valid is high and rd_ready low because no read is issued then
 wr_ptr_sync must already be in this clock domain
 empty is pessimistic, it clears only after the write pointer crosses over
*/
`timescale 1ns/1ns
`default_nettype none
`include "fifo_config.svh"

module async_fifo_rd_logic import fifo_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire fifo_ptr_t  wr_ptr_sync,  // write pointer, already synchronized
	input  wire fifo_word_t ram_rdata,    // registered RAM output
	input  wire logic       rd_ready,     // downstream takes the word
	output fifo_ptr_t       rd_ptr,       // to the pointer synchronizer
	output ram_addr_t       ram_raddr,
	output logic            ram_re,
	output logic            rd_valid,
	output fifo_word_t      rd_word
);

	logic      empty;
	logic      empty_next;
	logic      slot_free;     // output slot empty or draining this clock
	fifo_ptr_t rd_ptr_next1;  // rd_ptr + 1

	// ------------------------------------------------------------------------
	// RAM read request
	// ------------------------------------------------------------------------
	assign slot_free = !rd_valid || rd_ready;
	assign ram_re    = !empty && slot_free; // no read under back-pressure
	assign ram_raddr = rd_ptr[`FIFO_ADDR_WIDTH-2:0];

	// ------------------------------------------------------------------------
	// empty flag, one read ahead
	// ------------------------------------------------------------------------
	assign empty_next = (rd_ptr == wr_ptr_sync) ||
		(ram_re && (rd_ptr_next1 == wr_ptr_sync)); // last word leaving now

	always_ff @(posedge clk) begin
		if (reset) begin
			empty <= 1'b1;
		end else begin
			empty <= empty_next;
		end
	end

	// read pointer and its look-ahead, same start as the write side
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr       <= fifo_ptr_t'(1);
			rd_ptr_next1 <= fifo_ptr_t'(2);
		end else if (ram_re) begin
			rd_ptr       <= rd_ptr + fifo_ptr_t'(1);
			rd_ptr_next1 <= rd_ptr + fifo_ptr_t'(2);
		end
	end

	// ------------------------------------------------------------------------
	// output slot
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else if (ram_re) begin
			rd_valid <= 1'b1;     // RAM data lands next clock
		end else if (rd_ready) begin
			rd_valid <= 1'b0;     // drained, nothing behind it
		end
	end

	// data register lives in the RAM read port
	assign rd_word = ram_rdata;

endmodule

`default_nettype wire

//--- async_fifo.sv
/*
 dual-clock FIFO, valid/ready on both ports
 wr_ready is low during wr_reset and one clock after it
 rd_word is registered and holds while rd_valid is high and rd_ready low
 flags are pessimistic, each side sees the other pointer a few clocks late
 the two resets should overlap so both sides start from matching pointers
*/
`timescale 1ns/1ns
`default_nettype none

module async_fifo import fifo_pkg::*; (
	// write port, wr_clk domain
	input  wire logic       wr_clk,
	input  wire logic       wr_reset,
	input  wire logic       wr_valid,
	output logic            wr_ready,
	input  wire fifo_word_t wr_word,
	// read port, rd_clk domain
	input  wire logic       rd_clk,
	input  wire logic       rd_reset,
	output logic            rd_valid,
	input  wire logic       rd_ready,
	output fifo_word_t      rd_word
);

	fifo_ptr_t  wr_ptr;        // wr_clk domain
	fifo_ptr_t  wr_ptr_sync;   // wr_ptr seen on rd_clk
	fifo_ptr_t  rd_ptr;        // rd_clk domain
	fifo_ptr_t  rd_ptr_sync;   // rd_ptr seen on wr_clk
	ram_addr_t  ram_waddr;
	ram_addr_t  ram_raddr;
	logic       ram_we;
	logic       ram_re;
	logic       full;
	fifo_word_t ram_rdata;

	assign wr_ready = !full;

	// ------------------------------------------------------------------------
	// write domain
	// ------------------------------------------------------------------------
	async_fifo_wr_logic u_wr_logic (
		.clk         (wr_clk),
		.reset       (wr_reset),
		.wr_en       (wr_valid),     // gated by full inside
		.rd_ptr_sync (rd_ptr_sync),
		.wr_ptr      (wr_ptr),
		.ram_waddr   (ram_waddr),
		.ram_we      (ram_we),
		.full        (full)
	);

	async_fifo_ptr_sync u_wr_ptr_sync (   // wr_ptr into rd_clk
		.clk       (rd_clk),
		.src_clk   (wr_clk),
		.reset     (rd_reset),
		.src_reset (wr_reset),
		.src_ptr   (wr_ptr),
		.dst_ptr   (wr_ptr_sync)
	);

	// ------------------------------------------------------------------------
	// read domain
	// ------------------------------------------------------------------------
	async_fifo_rd_logic u_rd_logic (
		.clk         (rd_clk),
		.reset       (rd_reset),
		.wr_ptr_sync (wr_ptr_sync),
		.ram_rdata   (ram_rdata),
		.rd_ready    (rd_ready),
		.rd_ptr      (rd_ptr),
		.ram_raddr   (ram_raddr),
		.ram_re      (ram_re),
		.rd_valid    (rd_valid),
		.rd_word     (rd_word)
	);

	async_fifo_ptr_sync u_rd_ptr_sync (   // rd_ptr into wr_clk
		.clk       (wr_clk),
		.src_clk   (rd_clk),
		.reset     (wr_reset),
		.src_reset (rd_reset),
		.src_ptr   (rd_ptr),
		.dst_ptr   (rd_ptr_sync)
	);

	// storage shared by both domains
	async_fifo_dpram #(
		.word_t (fifo_word_t)
	) u_dpram (
		.wr_clk (wr_clk),
		.rd_clk (rd_clk),
		.we     (ram_we),
		.waddr  (ram_waddr),
		.wdata  (wr_word),
		.re     (ram_re),
		.raddr  (ram_raddr),
		.rdata  (ram_rdata)
	);

endmodule

`default_nettype wire

//--- tb_async_fifo.sv
/*
 self-checking testbench for the dual-clock FIFO
 wr_clk 10 ns, rd_clk 14 ns, so the edges only line up every 70 ns
 a queue scoreboard follows each accepted word from one domain to the other
 the first failed check ends the run
*/
`timescale 1ns/1ns
`default_nettype none
`include "fifo_config.svh"

module tb_async_fifo import fifo_pkg::*; ();

	localparam int DEPTH          = 2 ** (`FIFO_ADDR_WIDTH - 1); // 16 with the defaults
	localparam int TIMEOUT_CYCLES = 4000; // ~3x all traffic at the slowest rate

	logic       wr_clk = 1'b0;
	logic       rd_clk = 1'b0;
	logic       wr_reset;
	logic       rd_reset;
	logic       wr_valid;
	logic       wr_ready;
	fifo_word_t wr_word;
	logic       rd_valid;
	logic       rd_ready;
	fifo_word_t rd_word;

	fifo_word_t expected_q[$];      // scoreboard, oldest word first
	fifo_word_t popped;
	fifo_word_t hold_word;          // rd_word seen at the last stalled edge
	string      phase = "reset";
	int         wr_cycles = 0;
	logic       wr_reset_q = 1'b0;
	logic       rd_reset_q = 1'b0;
	logic       hold_q = 1'b0;      // rd_valid high, rd_ready low at the last edge

	always #5 wr_clk = ~wr_clk;
	always #7 rd_clk = ~rd_clk;

	async_fifo DUT (
		.wr_clk   (wr_clk),
		.wr_reset (wr_reset),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr_word  (wr_word),
		.rd_clk   (rd_clk),
		.rd_reset (rd_reset),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready),
		.rd_word  (rd_word)
	);

	task automatic value_error(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error %s: expected %0h actual %0h", name, expected, actual);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic plain_error(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	function automatic fifo_word_t random_word();
		logic [31:0] r;
		fifo_word_t  w;
		r      = $urandom;
		w.data = r[`FIFO_DATA_WIDTH-1:0];
		w.last = r[31];          // random frame ends
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// drivers, one per domain
	// ------------------------------------------------------------------------
	task automatic write_words(input int n, input int unsigned pct);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(posedge wr_clk);
			if (wr_valid && wr_ready) begin
				sent++;
			end
			if (!wr_valid || wr_ready) begin // no offer pending
				if (sent < n && $urandom_range(99) < pct) begin
					wr_valid <= 1'b1;
					wr_word  <= random_word();
				end else begin
					wr_valid <= 1'b0;
				end
			end
		end
	endtask

	task automatic read_words(input int n, input int unsigned pct);
		int got;
		got = 0;
		while (got < n) begin
			@(posedge rd_clk);
			if (rd_valid && rd_ready) begin
				got++;
			end
			rd_ready <= (got < n) && ($urandom_range(99) < pct);
		end
	endtask

	// wr_valid stuck high until wr_ready has stayed low for 50 clocks
	task automatic fill_until_full();
		int accepted;
		int low_run;
		accepted = 0;
		low_run  = 0;
		@(posedge wr_clk);
		wr_valid <= 1'b1;
		wr_word  <= random_word();
		while (low_run < 50) begin
			@(posedge wr_clk);
			if (wr_ready) begin
				accepted++;
				low_run = 0;
				wr_word <= random_word();
			end else begin
				low_run++;
			end
		end
		wr_valid <= 1'b0;
		assert (accepted == DEPTH) else value_error(phase, DEPTH, accepted);
	endtask

	// no word may show up after the last written one has left
	task automatic check_drained();
		repeat (10) begin // well past the write-to-read latency
			@(posedge rd_clk);
			assert (!rd_valid)
				else value_error({phase, "_drained"}, 0, 32'(rd_valid));
		end
	endtask

	// ------------------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------------------
	always @(posedge wr_clk) begin
		if (wr_reset_q) begin
			// full is set by reset, and still set one clock later
			assert (!wr_ready) else value_error("reset", 0, 32'(wr_ready));
		end
		if (!wr_reset && wr_valid && wr_ready) begin
			expected_q.push_back(wr_word);
		end
		wr_reset_q = wr_reset;
		wr_cycles++;
		if (wr_cycles >= TIMEOUT_CYCLES) begin
			$display("TEST FAIL");
			$fatal(1, "timeout, the run did not finish in %0d wr_clk cycles",
				TIMEOUT_CYCLES);
		end
	end

	always @(posedge rd_clk) begin
		if (rd_reset_q) begin
			assert (!rd_valid) else value_error("reset", 0, 32'(rd_valid));
		end
		if (hold_q) begin // stalled word must not move
			assert (rd_valid && rd_word == hold_word)
				else value_error({phase, "_hold"}, 32'(hold_word), 32'(rd_word));
		end
		if (!rd_reset && rd_valid && rd_ready) begin
			if (expected_q.size() == 0) begin
				plain_error("a word left the FIFO that was never written");
			end else begin
				popped = expected_q.pop_front();
				assert (rd_word == popped)
					else value_error(phase, 32'(popped), 32'(rd_word));
			end
		end
		rd_reset_q = rd_reset;
		hold_q     = !rd_reset && rd_valid && !rd_ready;
		hold_word  = rd_word;
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(32'hecb3));
		wr_reset <= 1'b1;
		rd_reset <= 1'b1;
		wr_valid <= 1'b0;
		wr_word  <= '0;
		rd_ready <= 1'b0;
		fork // 5 clocks of each domain's own clock
			begin
				repeat (5) @(posedge wr_clk);
				wr_reset <= 1'b0;
			end
			begin
				repeat (5) @(posedge rd_clk);
				rd_reset <= 1'b0;
			end
		join

		phase = "after_reset";
		@(posedge wr_clk);
		while (!wr_ready) @(posedge wr_clk);
		repeat (30) begin // no writes yet, so no reason to go full
			@(posedge wr_clk);
			assert (wr_ready) else value_error(phase, 1, 32'(wr_ready));
		end
		repeat (20) begin
			@(posedge rd_clk);
			assert (!rd_valid) else value_error(phase, 0, 32'(rd_valid));
		end

		phase = "in_order";
		fork
			write_words(40, 100);
			read_words(40, 100);
		join
		check_drained();

		phase = "fill";
		repeat (10) @(posedge wr_clk);
		fill_until_full(); // rd_ready still low from the last phase

		phase = "drain";
		read_words(DEPTH, 100);
		check_drained();
		repeat (50) begin
			@(posedge rd_clk);
			assert (!rd_valid) else value_error(phase, 0, 32'(rd_valid));
		end
		@(posedge wr_clk);
		assert (wr_ready) else value_error(phase, 1, 32'(wr_ready));

		phase = "random"; // pointers wrap many times in here
		fork
			write_words(200, 60);
			read_words(200, 60);
		join
		check_drained();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
fifo_pkg.sv
async_fifo_dpram.sv
async_fifo_ptr_sync.sv
async_fifo_wr_logic.sv
async_fifo_rd_logic.sv
async_fifo.sv
tb_async_fifo.sv

//--- Makefile
# dual-clock FIFO, Verilator simulation
# make        build and run the testbench, exit status is the result
# make lint   lint the RTL top level
# make clean  remove build output

TB = tb_async_fifo

.PHONY: all lint clean

all:
	verilator --binary --timing -f files.f --top-module $(TB)
	./obj_dir/V$(TB)

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module async_fifo

clean:
	rm -rf obj_dir
